/* Makefile */
# Verilator build and run of the SoC interconnect testbench

TOP = tb_soc

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* sim.f */
verilog/soc_pkg.sv
verilog/soc_ingress_buf.sv
verilog/soc_router.sv
verilog/soc_l2_mem.sv
verilog/soc_apb_bridge.sv
verilog/soc_ctrl_regs.sv
verilog/soc_top.sv
test/soc_chk.sv
test/tb_soc.sv

/* test/soc_chk.sv */
/*
  Protocol checks on the SoC top level, attached with bind. Covers the reset
  state, the credit bounds of both channels and the APB phases.
*/

module soc_chk (
  input logic              clk_i,
  input logic              rst_i,
  input logic              req_valid_i,
  input logic              req_credit_o,
  input logic              rsp_valid_o,
  input logic              rsp_credit_i,
  input soc_pkg::apb_req_t apb_o,
  input soc_pkg::apb_rsp_t apb_i,
  input soc_pkg::data_t    exit_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int req_out;
  int rsp_out;
  int fail_cnt = 0;

  // Requests not yet credited back, responses not yet acknowledged
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_out <= 0;
      rsp_out <= 0;
    end else begin
      req_out <= req_out + int'(req_valid_i) - int'(req_credit_o);
      rsp_out <= rsp_out + int'(rsp_valid_o) - int'(rsp_credit_i);
    end
  end

  reset_idle: assert property (@(posedge clk_i) $past(rst_i) |->
      !req_credit_o && !rsp_valid_o && !apb_o.psel && !apb_o.penable && exit_o == '0)
    else begin fail_cnt++; $error("outputs not idle during or after reset"); end

  // A credit may only come back for a slot the master has filled
  req_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      req_out >= 0 && req_out <= soc_pkg::ReqCredits)
    else begin fail_cnt++; $error("request credit count out of range"); end

  rsp_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      rsp_out <= soc_pkg::RspCredits)
    else begin fail_cnt++; $error("more responses unacknowledged than credits"); end

  rsp_stop: assert property (@(posedge clk_i) disable iff (rst_i)
      rsp_valid_o |-> rsp_out < soc_pkg::RspCredits)
    else begin fail_cnt++; $error("response sent without a credit"); end

  //////////////////////////////
  // APB phases

  apb_setup_first: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(apb_o.penable) |-> $past(apb_o.psel))
    else begin fail_cnt++; $error("penable rose without a setup cycle"); end

  apb_setup_to_access: assert property (@(posedge clk_i) disable iff (rst_i)
      apb_o.psel && !apb_o.penable |=> apb_o.psel && apb_o.penable)
    else begin fail_cnt++; $error("setup cycle not followed by access"); end

  apb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      apb_o.penable && !apb_i.pready |=> apb_o.penable)
    else begin fail_cnt++; $error("penable dropped before pready"); end

  apb_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      apb_o.penable |-> $stable({apb_o.paddr, apb_o.pwrite, apb_o.pwdata}))
    else begin fail_cnt++; $error("APB address or data changed in transfer"); end

endmodule

bind soc_top soc_chk i_chk (
  .clk_i        (clk_i       ),
  .rst_i        (rst_i       ),
  .req_valid_i  (req_valid_i ),
  .req_credit_o (req_credit_o),
  .rsp_valid_o  (rsp_valid_o ),
  .rsp_credit_i (rsp_credit_i),
  .apb_o        (apb_o       ),
  .apb_i        (apb_i       ),
  .exit_o       (exit_o      )
);

/* test/tb_soc.sv */
/*
  Testbench for the SoC interconnect. Acts as the credit-based master, models
  the UART APB slave and predicts every response in request order.
*/

module tb_soc;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumReqs   = 42;
  localparam int UartWords = 16;

  typedef struct packed {
    soc_pkg::soc_rsp_t rsp;
    logic              chk_data;
    soc_pkg::data_t    exit_val;
  } exp_t;

  logic               clk_i;
  logic               rst_i;
  logic               req_valid_i;
  soc_pkg::soc_req_t  req_i;
  logic               req_credit_o;
  logic               rsp_valid_o;
  soc_pkg::soc_rsp_t  rsp_o;
  logic               rsp_credit_i;
  soc_pkg::apb_req_t  apb_o;
  soc_pkg::apb_rsp_t  apb_i;
  soc_pkg::data_t     exit_o;

  int                 seed = 32'h6c8d;
  int                 errors = 0;
  int                 checks = 0;
  int                 req_credits = soc_pkg::ReqCredits;
  int                 owed = 0;
  int                 crd_roll;
  int                 apb_roll;
  int                 slv_idx;
  logic               hold_credits = 1'b0;
  exp_t               exp_q [$];
  exp_t               head_exp;
  soc_pkg::data_t     rnd;
  soc_pkg::data_t     l2_ref [4];
  soc_pkg::data_t     exit_ref = '0;
  soc_pkg::apb_data_t uart_ref [UartWords];
  soc_pkg::apb_data_t uart_mem [UartWords];

  soc_top uut (
    .clk_i        (clk_i       ),
    .rst_i        (rst_i       ),
    .req_valid_i  (req_valid_i ),
    .req_i        (req_i       ),
    .req_credit_o (req_credit_o),
    .rsp_valid_o  (rsp_valid_o ),
    .rsp_o        (rsp_o       ),
    .rsp_credit_i (rsp_credit_i),
    .apb_o        (apb_o       ),
    .apb_i        (apb_i       ),
    .exit_o       (exit_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference helpers

  function automatic soc_pkg::data_t merge_bytes(input soc_pkg::data_t old,
                                                 input soc_pkg::data_t wdata,
                                                 input soc_pkg::strb_t strb);
    soc_pkg::data_t res;
    res = old;
    for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
      if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  function automatic soc_pkg::apb_data_t uart_fill(input int idx);
    return 32'h7e00_1000 + soc_pkg::apb_data_t'(idx) * 32'h0101_0101;
  endfunction

  // Words 3 and 9 of the UART model answer with pslverr
  function automatic logic uart_faulty(input int idx);
    return (idx == 3) || (idx == 9);
  endfunction

  task automatic expect_rsp(input soc_pkg::data_t rdata, input logic chk, input logic err);
    exp_t e;
    e.rsp.rdata = rdata;
    e.rsp.err   = err;
    e.chk_data  = chk;
    e.exit_val  = exit_ref;
    exp_q.push_back(e);
  endtask

  // Called on a falling edge, returns on the next one
  task automatic send_req(input soc_pkg::addr_t addr, input logic we,
                          input soc_pkg::data_t wdata, input soc_pkg::strb_t strb);
    while (req_credits == 0) @(negedge clk_i);
    req_credits--;
    req_valid_i = 1'b1;
    req_i       = '{addr: addr, we: we, wdata: wdata, strb: strb};
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic l2_access(input int idx, input logic we, input soc_pkg::data_t wdata,
                           input soc_pkg::strb_t strb);
    expect_rsp(l2_ref[idx], !we, 1'b0);
    if (we) l2_ref[idx] = merge_bytes(l2_ref[idx], wdata, strb);
    send_req(soc_pkg::DramBase + soc_pkg::addr_t'(idx << 3), we, wdata, strb);
  endtask

  task automatic ctrl_access(input int offset, input logic we, input soc_pkg::data_t wdata,
                             input soc_pkg::strb_t strb);
    if (offset == 0 && we) exit_ref = merge_bytes(exit_ref, wdata, strb);
    expect_rsp(exit_ref, !we && offset == 0, offset != 0);
    send_req(soc_pkg::CtrlBase + soc_pkg::addr_t'(offset), we, wdata, strb);
  endtask

  task automatic uart_access(input int idx, input logic we, input soc_pkg::data_t wdata);
    expect_rsp(soc_pkg::data_t'(uart_ref[idx]), !we, uart_faulty(idx));
    if (we && !uart_faulty(idx)) uart_ref[idx] = wdata[31:0];
    send_req(soc_pkg::UartBase + soc_pkg::addr_t'(idx << 2), we, wdata, '1);
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0 || owed != 0) @(negedge clk_i);
  endtask

  //////////////////////////////
  // Master, APB slave, monitor

  always @(posedge clk_i) begin
    if (!rst_i && req_credit_o) req_credits++;
  end

  always @(negedge clk_i) begin
    apb_roll = $random(seed);
    apb_i    = '0;
    if (apb_o.psel && apb_o.penable && apb_roll[0]) begin
      slv_idx       = int'(apb_o.paddr[5:2]);
      apb_i.pready  = 1'b1;
      apb_i.pslverr = uart_faulty(slv_idx);
      if (!apb_o.pwrite) apb_i.prdata = uart_mem[slv_idx];
      else if (!uart_faulty(slv_idx)) uart_mem[slv_idx] = apb_o.pwdata;
    end
  end

  always @(negedge clk_i) begin
    if (!rst_i && rsp_valid_o) begin
      checks++;
      owed++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("response arrived at %0t with no request outstanding", $time);
      end else begin
        head_exp = exp_q.pop_front();
        assert final ((!head_exp.chk_data || rsp_o.rdata == head_exp.rsp.rdata) &&
                      rsp_o.err == head_exp.rsp.err && exit_o == head_exp.exit_val)
        else begin
          errors++;
          $display("mismatch at %0t: got rdata %h err %b exit %h, expected rdata %h err %b exit %h",
                   $time, rsp_o.rdata, rsp_o.err, exit_o, head_exp.rsp.rdata,
                   head_exp.rsp.err, head_exp.exit_val);
        end
      end
    end
    // Credit goes back after a random delay
    crd_roll     = $random(seed);
    rsp_credit_i = 1'b0;
    if (owed > 0 && !hold_credits && crd_roll[1:0] != 2'b00) begin
      rsp_credit_i = 1'b1;
      owed--;
    end
  end

  initial begin
    repeat (NumReqs * 40 + 200) @(posedge clk_i);
    $display("timeout: responses still missing after %0d cycles", NumReqs * 40 + 200);
    $display("tests failed");
    $finish;
  end

  //////////////////////////////
  // Stimulus

  initial begin
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_i        = '0;
    rsp_credit_i = 1'b0;
    apb_i        = '0;
    for (int i = 0; i < UartWords; i++) begin
      uart_ref[i] = uart_fill(i);
      uart_mem[i] = uart_fill(i);
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // L2 whole words, then partial strobes
    for (int i = 0; i < 4; i++) l2_access(i, 1'b1, {$random(seed), $random(seed)}, '1);
    l2_access(1, 1'b1, 64'h1122_3344_5566_7788, 8'b1010_0101);
    l2_access(1, 1'b0, '0, '0);
    for (int i = 0; i < 12; i++) begin
      rnd = {$random(seed), $random(seed)};
      l2_access(int'(rnd[1:0]), rnd[2], {$random(seed), $random(seed)}, rnd[15:8]);
    end

    // Exit register and a bad control offset
    ctrl_access(0, 1'b1, 64'h0123_4567_89ab_cdef, 8'h33);
    ctrl_access(0, 1'b0, '0, '0);
    ctrl_access(8, 1'b1, '1, '1);
    ctrl_access(8, 1'b0, '0, '0);
    ctrl_access(0, 1'b1, 64'hfeed_0000_0000_beef, 8'hc0);
    ctrl_access(0, 1'b0, '0, '0);

    for (int i = 0; i < 4; i++) uart_access(i, 1'b1, {$random(seed), $random(seed)});
    for (int i = 0; i < 4; i++) uart_access(i, 1'b0, '0);
    uart_access(9, 1'b0, '0);

    // Unmapped address, then L2 word 0 must be intact
    expect_rsp('0, 1'b0, 1'b1);
    send_req(32'h1000_0000, 1'b1, '1, '1);
    expect_rsp('0, 1'b0, 1'b1);
    send_req(32'h1000_0000, 1'b0, '0, '0);
    l2_access(0, 1'b0, '0, '0);

    // Back-pressure on the response channel
    wait_idle();
    hold_credits = 1'b1;
    for (int i = 0; i < 6; i++) l2_access(i % 4, 1'b0, '0, '0);
    repeat (30) @(negedge clk_i);
    hold_credits = 1'b0;

    wait_idle();
    repeat (4) @(negedge clk_i);
    if (checks != NumReqs) begin
      errors++;
      $display("expected %0d responses but checked %0d", NumReqs, checks);
    end
    $display("summary: %0d response errors, %0d assertion failures, %0d responses checked",
             errors, uut.i_chk.fail_cnt, checks);
    if (errors == 0 && uut.i_chk.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* verilog/soc_apb_bridge.sv */
/*
  Turns one routed request into a single APB transfer for the UART.
  The response follows one cycle after pready is seen in the access phase.
*/

module soc_apb_bridge (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  input  soc_pkg::soc_req_t req_i,
  output logic              valid_o,
  output soc_pkg::soc_rsp_t rsp_o,
  output soc_pkg::apb_req_t apb_o,
  input  soc_pkg::apb_rsp_t apb_i
);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_e;

  state_e             state_q;
  soc_pkg::apb_addr_t paddr_q;
  soc_pkg::apb_data_t pwdata_q;
  logic               pwrite_q;
  soc_pkg::soc_rsp_t  rsp_q;
  logic               valid_q;
  logic               done;

  assign done = (state_q == ACCESS) && apb_i.pready;

  // Address and data held in registers keep the bus stable until pready
  assign apb_o = '{
    psel:    (state_q != IDLE),
    penable: (state_q == ACCESS),
    pwrite:  pwrite_q,
    paddr:   paddr_q,
    pwdata:  pwdata_q
  };

  assign valid_o = valid_q;
  assign rsp_o   = rsp_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      valid_q <= 1'b0;
    end else begin
      valid_q <= done;
      case (state_q)
        IDLE:    if (valid_i) state_q <= SETUP;
        SETUP:   state_q <= ACCESS;
        ACCESS:  if (apb_i.pready) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && valid_i) begin
      paddr_q  <= req_i.addr[soc_pkg::ApbAddrWidth-1:0];
      pwdata_q <= req_i.wdata[soc_pkg::ApbDataWidth-1:0];
      pwrite_q <= req_i.we;
    end
    if (done) begin
      rsp_q.rdata <= soc_pkg::data_t'(apb_i.prdata);
      rsp_q.err   <= apb_i.pslverr;
    end
  end

endmodule

/* verilog/soc_ctrl_regs.sv */
/*
  Control-register block next to the router. Holds the exit register at
  offset 0 of the control region and flags every other offset as an error.
*/

module soc_ctrl_regs (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  input  soc_pkg::soc_req_t req_i,
  output logic              valid_o,
  output soc_pkg::soc_rsp_t rsp_o,
  output soc_pkg::data_t    exit_o
);

  soc_pkg::data_t    exit_q;
  soc_pkg::soc_rsp_t rsp_q;
  logic              valid_q;
  logic              hit;

  assign hit     = (req_i.addr == soc_pkg::CtrlBase);
  assign exit_o  = exit_q;
  assign valid_o = valid_q;
  assign rsp_o   = rsp_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
      if (valid_i && hit && req_i.we) begin
        for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
          if (req_i.strb[b]) exit_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Reads see the value before a same-cycle write
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rsp_q.rdata <= hit ? exit_q : '0;
      rsp_q.err   <= !hit;
    end
  end

endmodule

/* verilog/soc_ingress_buf.sv */
/*
  Request FIFO sized to the request credits. Each pop frees one slot and
  returns one credit to the master a cycle later.
*/

module soc_ingress_buf (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              push_i,
  input  soc_pkg::soc_req_t push_req_i,
  output logic              head_valid_o,
  output soc_pkg::soc_req_t head_o,
  input  logic              pop_i,
  output logic              credit_o
);

  soc_pkg::soc_req_t mem_q [soc_pkg::ReqCredits];
  soc_pkg::req_ptr_t wptr_q;
  soc_pkg::req_ptr_t rptr_q;
  soc_pkg::req_cnt_t count_q;
  logic              credit_q;

  function automatic soc_pkg::req_ptr_t next_ptr(input soc_pkg::req_ptr_t ptr);
    if (ptr == soc_pkg::req_ptr_t'(soc_pkg::ReqCredits - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rptr_q];
  assign credit_o     = credit_q;

  // Pointers, fill level and credit return
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_q   <= '0;
      rptr_q   <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop_i;
      if (push_i) wptr_q <= next_ptr(wptr_q);
      if (pop_i)  rptr_q <= next_ptr(rptr_q);
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wptr_q] <= push_req_i;
  end

endmodule

/* verilog/soc_l2_mem.sv */
/*
  L2 SRAM, word addressed, with byte-strobe writes.
  Answers every request exactly one cycle after its valid.
*/

module soc_l2_mem (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  input  soc_pkg::soc_req_t req_i,
  output logic              valid_o,
  output soc_pkg::soc_rsp_t rsp_o
);

  soc_pkg::data_t   mem_q [soc_pkg::L2NumWords];
  soc_pkg::data_t   rdata_q;
  soc_pkg::l2_idx_t idx;
  logic             valid_q;

  // Word index sits above the byte offset
  assign idx     = req_i.addr[soc_pkg::L2IdxLsb +: $bits(soc_pkg::l2_idx_t)];
  assign valid_o = valid_q;
  assign rsp_o   = '{rdata: rdata_q, err: 1'b0};

  always_ff @(posedge clk_i) begin
    if (rst_i) valid_q <= 1'b0;
    else       valid_q <= valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rdata_q <= mem_q[idx];
      if (req_i.we) begin
        for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
          if (req_i.strb[b]) mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

/* verilog/soc_pkg.sv */
/*
  Shared widths, memory map, credit counts and bus types of the SoC interconnect.
  Every RTL module refers to these by scoped name.
*/

package soc_pkg;

  //////////////////////////////
  // Widths

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned ApbAddrWidth = 32;
  localparam int unsigned ApbDataWidth = 32;
  localparam int unsigned L2NumWords   = 1024;
  localparam int unsigned L2IdxLsb     = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0]          addr_t;
  typedef logic [DataWidth-1:0]          data_t;
  typedef logic [StrbWidth-1:0]          strb_t;
  typedef logic [ApbAddrWidth-1:0]       apb_addr_t;
  typedef logic [ApbDataWidth-1:0]       apb_data_t;
  typedef logic [$clog2(L2NumWords)-1:0] l2_idx_t;

  //////////////////////////////
  // Memory map

  localparam addr_t DramBase   = 32'h8000_0000;
  localparam addr_t DramLength = 32'h0000_2000;
  localparam addr_t UartBase   = 32'hC000_0000;
  localparam addr_t UartLength = 32'h0000_1000;
  localparam addr_t CtrlBase   = 32'hD000_0000;
  localparam addr_t CtrlLength = 32'h0000_1000;

  //////////////////////////////
  // Credits

  localparam int unsigned ReqCredits  = 4;
  localparam int unsigned RspCredits  = 2;
  localparam int unsigned ReqPtrWidth = $clog2(ReqCredits);
  localparam int unsigned ReqCntWidth = $clog2(ReqCredits + 1);
  localparam int unsigned RspCntWidth = $clog2(RspCredits + 1);

  typedef logic [ReqPtrWidth-1:0] req_ptr_t;
  typedef logic [ReqCntWidth-1:0] req_cnt_t;
  typedef logic [RspCntWidth-1:0] rsp_cnt_t;

  //////////////////////////////
  // Bus types

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_UART,
    TGT_CTRL,
    TGT_NONE
  } target_e;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    strb_t strb;
  } soc_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } soc_rsp_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

endpackage

/* verilog/soc_router.sv */
/*
  Address router. Pops one request, decodes it against the memory map, sends
  it to a single target and returns the response while response credits last.
*/

module soc_router (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              head_valid_i,
  input  soc_pkg::soc_req_t head_i,
  output logic              pop_o,
  input  logic              rsp_credit_i,
  output logic              rsp_valid_o,
  output soc_pkg::soc_rsp_t rsp_o,
  output soc_pkg::soc_req_t tgt_req_o,
  output logic              l2_valid_o,
  input  logic              l2_valid_i,
  input  soc_pkg::soc_rsp_t l2_rsp_i,
  output logic              apb_valid_o,
  input  logic              apb_valid_i,
  input  soc_pkg::soc_rsp_t apb_rsp_i,
  output logic              ctrl_valid_o,
  input  logic              ctrl_valid_i,
  input  soc_pkg::soc_rsp_t ctrl_rsp_i
);

  typedef enum logic [1:0] {IDLE, WAIT, RESP} state_e;

  state_e            state_q;
  soc_pkg::target_e  tgt_q;
  soc_pkg::soc_req_t req_q;
  soc_pkg::soc_rsp_t rsp_q;
  soc_pkg::soc_rsp_t tgt_rsp;
  soc_pkg::rsp_cnt_t credit_q;
  logic              start;
  logic              dispatch_q;
  logic              none_valid_q;
  logic              tgt_valid;

  function automatic soc_pkg::target_e decode(input soc_pkg::addr_t addr);
    if (addr >= soc_pkg::DramBase && addr < soc_pkg::DramBase + soc_pkg::DramLength) begin
      return soc_pkg::TGT_L2;
    end
    if (addr >= soc_pkg::UartBase && addr < soc_pkg::UartBase + soc_pkg::UartLength) begin
      return soc_pkg::TGT_UART;
    end
    if (addr >= soc_pkg::CtrlBase && addr < soc_pkg::CtrlBase + soc_pkg::CtrlLength) begin
      return soc_pkg::TGT_CTRL;
    end
    return soc_pkg::TGT_NONE;
  endfunction

  // Only start when the finished response is sure to leave
  assign start       = (state_q == IDLE) && head_valid_i && (credit_q != '0);
  assign pop_o       = start;
  assign rsp_valid_o = (state_q == RESP);
  assign rsp_o       = rsp_q;
  assign tgt_req_o   = req_q;

  assign l2_valid_o   = dispatch_q && (tgt_q == soc_pkg::TGT_L2);
  assign apb_valid_o  = dispatch_q && (tgt_q == soc_pkg::TGT_UART);
  assign ctrl_valid_o = dispatch_q && (tgt_q == soc_pkg::TGT_CTRL);

  always_comb begin
    case (tgt_q)
      soc_pkg::TGT_L2: begin
        tgt_valid = l2_valid_i;
        tgt_rsp   = l2_rsp_i;
      end
      soc_pkg::TGT_UART: begin
        tgt_valid = apb_valid_i;
        tgt_rsp   = apb_rsp_i;
      end
      soc_pkg::TGT_CTRL: begin
        tgt_valid = ctrl_valid_i;
        tgt_rsp   = ctrl_rsp_i;
      end
      default: begin
        tgt_valid = none_valid_q;
        tgt_rsp   = '{rdata: '0, err: 1'b1};
      end
    endcase
  end

  //////////////////////////////
  // Dispatch FSM

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= IDLE;
      tgt_q        <= soc_pkg::TGT_NONE;
      dispatch_q   <= 1'b0;
      none_valid_q <= 1'b0;
    end else begin
      dispatch_q   <= start;
      // Unmapped requests answer one cycle after dispatch
      none_valid_q <= dispatch_q && (tgt_q == soc_pkg::TGT_NONE);
      case (state_q)
        IDLE: begin
          if (start) begin
            tgt_q   <= decode(head_i.addr);
            state_q <= WAIT;
          end
        end
        WAIT:    if (tgt_valid) state_q <= RESP;
        RESP:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) req_q <= head_i;
    if (state_q == WAIT && tgt_valid) rsp_q <= tgt_rsp;
  end

  //////////////////////////////
  // Response credits

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_q <= soc_pkg::rsp_cnt_t'(soc_pkg::RspCredits);
    end else begin
      case ({rsp_credit_i, rsp_valid_o})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

/* verilog/soc_top.sv */
/*
  SoC interconnect top level. A credit-based master port feeds the ingress
  buffer, the router dispatches to L2, the UART APB bridge or the control block.
*/

module soc_top (
  input  logic               clk_i,
  input  logic               rst_i,
  // Master request port
  input  logic               req_valid_i,
  input  soc_pkg::soc_req_t  req_i,
  output logic               req_credit_o,
  // Master response port
  output logic               rsp_valid_o,
  output soc_pkg::soc_rsp_t  rsp_o,
  input  logic               rsp_credit_i,
  // UART APB
  output soc_pkg::apb_req_t  apb_o,
  input  soc_pkg::apb_rsp_t  apb_i,
  output soc_pkg::data_t     exit_o
);

  logic              head_valid;
  logic              pop;
  soc_pkg::soc_req_t head;
  soc_pkg::soc_req_t tgt_req;

  logic              l2_req_valid;
  logic              l2_rsp_valid;
  soc_pkg::soc_rsp_t l2_rsp;
  logic              apb_req_valid;
  logic              apb_rsp_valid;
  soc_pkg::soc_rsp_t apb_rsp;
  logic              ctrl_req_valid;
  logic              ctrl_rsp_valid;
  soc_pkg::soc_rsp_t ctrl_rsp;

  soc_ingress_buf i_ingress_buf (
    .clk_i        (clk_i       ),
    .rst_i        (rst_i       ),
    .push_i       (req_valid_i ),
    .push_req_i   (req_i       ),
    .head_valid_o (head_valid  ),
    .head_o       (head        ),
    .pop_i        (pop         ),
    .credit_o     (req_credit_o)
  );

  soc_router i_router (
    .clk_i        (clk_i         ),
    .rst_i        (rst_i         ),
    .head_valid_i (head_valid    ),
    .head_i       (head          ),
    .pop_o        (pop           ),
    .rsp_credit_i (rsp_credit_i  ),
    .rsp_valid_o  (rsp_valid_o   ),
    .rsp_o        (rsp_o         ),
    .tgt_req_o    (tgt_req       ),
    .l2_valid_o   (l2_req_valid  ),
    .l2_valid_i   (l2_rsp_valid  ),
    .l2_rsp_i     (l2_rsp        ),
    .apb_valid_o  (apb_req_valid ),
    .apb_valid_i  (apb_rsp_valid ),
    .apb_rsp_i    (apb_rsp       ),
    .ctrl_valid_o (ctrl_req_valid),
    .ctrl_valid_i (ctrl_rsp_valid),
    .ctrl_rsp_i   (ctrl_rsp      )
  );

  soc_l2_mem i_l2_mem (
    .clk_i   (clk_i       ),
    .rst_i   (rst_i       ),
    .valid_i (l2_req_valid),
    .req_i   (tgt_req     ),
    .valid_o (l2_rsp_valid),
    .rsp_o   (l2_rsp      )
  );

  soc_apb_bridge i_apb_bridge_uart (
    .clk_i   (clk_i        ),
    .rst_i   (rst_i        ),
    .valid_i (apb_req_valid),
    .req_i   (tgt_req      ),
    .valid_o (apb_rsp_valid),
    .rsp_o   (apb_rsp      ),
    .apb_o   (apb_o        ),
    .apb_i   (apb_i        )
  );

  soc_ctrl_regs i_ctrl_regs (
    .clk_i   (clk_i         ),
    .rst_i   (rst_i         ),
    .valid_i (ctrl_req_valid),
    .req_i   (tgt_req       ),
    .valid_o (ctrl_rsp_valid),
    .rsp_o   (ctrl_rsp      ),
    .exit_o  (exit_o        )
  );

endmodule
